/* logic/sad_pkg.sv */
`default_nettype none

// Pixel and block geometry for the SAD datapath
package sad_pkg;

	localparam int BLOCK_DIM    = 4; // Block side in pixels
	localparam int BLOCK_PIXELS = BLOCK_DIM * BLOCK_DIM;
	localparam int PIXEL_W      = 8;

	// 16 x 255 = 4080 fits in 12 bits
	localparam int SAD_W = 12;

	typedef logic [PIXEL_W-1:0] pixel_t;

	// Row r, column c at slot r*BLOCK_DIM + c, slot 0 in the low byte
	typedef logic [BLOCK_PIXELS*PIXEL_W-1:0] block_t;

	typedef logic [SAD_W-1:0] sad_t;

	localparam sad_t SAD_MAX = '1; // Worst possible match

endpackage

`default_nettype wire

/* logic/search_pkg.sv */
`default_nettype none

// Search array layout, result format and pipeline depths
package search_pkg;

	localparam int N_PE     = 16;
	localparam int PE_IDX_W = $clog2(N_PE);
	localparam int CTR_W    = 4;
	localparam int MATCH_W  = sad_pkg::SAD_W + CTR_W + PE_IDX_W;

	typedef logic [PE_IDX_W-1:0] pe_idx_t;

	// Candidate row/offset tag from the outside
	typedef logic [CTR_W-1:0] ctr_word_t;

	// SAD in 19..8, control word in 7..4, element index in 3..0
	typedef logic [MATCH_W-1:0] match_t;

	typedef logic [N_PE*$bits(sad_pkg::block_t)-1:0] pe_blocks_t; // Element k in slice k
	typedef logic [N_PE*sad_pkg::SAD_W-1:0] pe_sads_t;

	localparam int PE_LAT    = 2;
	localparam int TREE_LAT  = 2;
	localparam int ALIGN_LAT = PE_LAT + TREE_LAT; // Enable and ctr_word delay

	localparam match_t MATCH_WORST = {
		sad_pkg::SAD_MAX,
		{CTR_W{1'b0}},
		{PE_IDX_W{1'b0}}
	};

endpackage

`default_nettype wire

/* logic/sad_pe.sv */
`timescale 1ns/1ns
`default_nettype none

// One 4x4 SAD element, absolute differences then sum
module sad_pe (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire sad_pkg::block_t cur_blk,
	input  wire sad_pkg::block_t ref_blk,
	output sad_pkg::sad_t        sad
);

	sad_pkg::pixel_t cur_px [sad_pkg::BLOCK_PIXELS];
	sad_pkg::pixel_t ref_px [sad_pkg::BLOCK_PIXELS];
	sad_pkg::pixel_t diff_q [sad_pkg::BLOCK_PIXELS];
	sad_pkg::sad_t   sum_d;

	function automatic sad_pkg::pixel_t abs_diff(
		input sad_pkg::pixel_t a,
		input sad_pkg::pixel_t b
	);
		if (a > b)
			abs_diff = a - b;
		else
			abs_diff = b - a;
	endfunction

	// Split the packed blocks into pixels
	always_comb
	begin
		for (int i = 0; i < sad_pkg::BLOCK_PIXELS; i++)
		begin
			cur_px[i] = cur_blk[i*sad_pkg::PIXEL_W +: sad_pkg::PIXEL_W];
			ref_px[i] = ref_blk[i*sad_pkg::PIXEL_W +: sad_pkg::PIXEL_W];
		end
	end

	// Stage one
	always_ff @(posedge clk)
	begin
		if (rst_n)
		begin
			for (int i = 0; i < sad_pkg::BLOCK_PIXELS; i++)
			begin
				diff_q[i] <= '0;
			end
		end
		else
		begin
			for (int i = 0; i < sad_pkg::BLOCK_PIXELS; i++)
			begin
				diff_q[i] <= abs_diff(cur_px[i], ref_px[i]);
			end
		end
	end

	// Adder tree over the sixteen differences
	always_comb
	begin
		sum_d = '0;
		for (int i = 0; i < sad_pkg::BLOCK_PIXELS; i++)
		begin
			sum_d = sum_d + sad_pkg::sad_t'(diff_q[i]); // Zero extend
		end
	end

	// Stage two
	always_ff @(posedge clk)
	begin
		if (rst_n)
			sad <= '0;
		else
			sad <= sum_d;
	end

endmodule

`default_nettype wire

/* logic/min_select_tree.sv */
`timescale 1ns/1ns
`default_nettype none

// Minimum of sixteen SADs in two registered levels of four
module min_select_tree (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire search_pkg::pe_sads_t sads,
	output sad_pkg::sad_t             min_sad,
	output search_pkg::pe_idx_t       min_idx
);

	sad_pkg::sad_t       sad_in    [search_pkg::N_PE];
	sad_pkg::sad_t       grp_sad_d [4];
	search_pkg::pe_idx_t grp_idx_d [4];
	sad_pkg::sad_t       grp_sad_q [4];
	search_pkg::pe_idx_t grp_idx_q [4];
	sad_pkg::sad_t       fin_sad_d;
	search_pkg::pe_idx_t fin_idx_d;

	// Shared by both levels
	function automatic void min_of_four(
		input  sad_pkg::sad_t       s  [4],
		input  search_pkg::pe_idx_t ix [4],
		output sad_pkg::sad_t       min_s,
		output search_pkg::pe_idx_t min_i
	);
		min_s = s[0];
		min_i = ix[0];
		for (int j = 1; j < 4; j++)
		begin
			if (s[j] < min_s) // Strict, so a tie keeps the lower index
			begin
				min_s = s[j];
				min_i = ix[j];
			end
		end
	endfunction

	always_comb
	begin
		for (int k = 0; k < search_pkg::N_PE; k++)
		begin
			sad_in[k] = sads[k*sad_pkg::SAD_W +: sad_pkg::SAD_W];
		end
	end

	// Level one, groups 0..3 cover elements 4g..4g+3
	always_comb
	begin
		sad_pkg::sad_t       s  [4];
		search_pkg::pe_idx_t ix [4];
		sad_pkg::sad_t       m_s;
		search_pkg::pe_idx_t m_i;
		for (int g = 0; g < 4; g++)
		begin
			for (int j = 0; j < 4; j++)
			begin
				s[j]  = sad_in[g*4 + j];
				ix[j] = search_pkg::pe_idx_t'(g*4 + j);
			end
			min_of_four(s, ix, m_s, m_i);
			grp_sad_d[g] = m_s;
			grp_idx_d[g] = m_i;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst_n)
		begin
			for (int g = 0; g < 4; g++)
			begin
				grp_sad_q[g] <= '0;
				grp_idx_q[g] <= '0;
			end
		end
		else
		begin
			for (int g = 0; g < 4; g++)
			begin
				grp_sad_q[g] <= grp_sad_d[g];
				grp_idx_q[g] <= grp_idx_d[g];
			end
		end
	end

	// Level two over the group winners, in group order
	always_comb
	begin
		min_of_four(grp_sad_q, grp_idx_q, fin_sad_d, fin_idx_d);
	end

	always_ff @(posedge clk)
	begin
		if (rst_n)
		begin
			min_sad <= '0;
			min_idx <= '0;
		end
		else
		begin
			min_sad <= fin_sad_d;
			min_idx <= fin_idx_d;
		end
	end

endmodule

`default_nettype wire

/* logic/best_match_tracker.sv */
`timescale 1ns/1ns
`default_nettype none

// Aligns enable and ctr_word with the SAD pipeline and keeps the running best
module best_match_tracker (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        enable,
	input  wire search_pkg::ctr_word_t ctr_word,
	input  wire sad_pkg::sad_t         min_sad,
	input  wire search_pkg::pe_idx_t   min_idx,
	output search_pkg::match_t         best_match
);

	logic                  en_dly  [search_pkg::ALIGN_LAT];
	search_pkg::ctr_word_t ctr_dly [search_pkg::ALIGN_LAT];
	logic                  en_aligned;
	sad_pkg::sad_t         best_sad;
	logic                  keep_best;
	search_pkg::match_t    new_match;

	always_ff @(posedge clk)
	begin
		if (rst_n)
		begin
			for (int i = 0; i < search_pkg::ALIGN_LAT; i++)
			begin
				en_dly[i] <= 1'b0;
			end
		end
		else
		begin
			en_dly[0] <= enable;
			for (int i = 1; i < search_pkg::ALIGN_LAT; i++)
			begin
				en_dly[i] <= en_dly[i-1];
			end
		end
	end

	// Control word delay, same depth as enable
	always_ff @(posedge clk)
	begin
		ctr_dly[0] <= ctr_word;
		for (int i = 1; i < search_pkg::ALIGN_LAT; i++)
		begin
			ctr_dly[i] <= ctr_dly[i-1];
		end
	end

	assign en_aligned = en_dly[search_pkg::ALIGN_LAT-1];
	assign best_sad   = best_match[search_pkg::MATCH_W-1 -: sad_pkg::SAD_W];
	assign keep_best  = best_sad < min_sad; // An equal SAD replaces the old one
	assign new_match  = {min_sad, ctr_dly[search_pkg::ALIGN_LAT-1], min_idx};

	always_ff @(posedge clk)
	begin
		if (rst_n || !en_aligned)
			best_match <= search_pkg::MATCH_WORST; // Restart from the worst match
		else if (!keep_best)
			best_match <= new_match;
	end

endmodule

`default_nettype wire

/* logic/me_calculate.sv */
`timescale 1ns/1ns
`default_nettype none

// Full-search motion estimation over sixteen candidate blocks per cycle
module me_calculate (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire                         enable,
	input  wire search_pkg::ctr_word_t  ctr_word,
	input  wire search_pkg::pe_blocks_t cur_blocks,
	input  wire search_pkg::pe_blocks_t ref_blocks,
	output search_pkg::match_t          best_match
);

	wire search_pkg::pe_sads_t sads;
	wire sad_pkg::sad_t        min_sad;
	wire search_pkg::pe_idx_t  min_idx;

	// Element k takes slice k of both block buses
	for (genvar k = 0; k < search_pkg::N_PE; k++)
	begin : g_pe
		sad_pe sad_pe_inst (
			.clk     (clk),
			.rst_n   (rst_n),
			.cur_blk (cur_blocks[k*$bits(sad_pkg::block_t) +: $bits(sad_pkg::block_t)]),
			.ref_blk (ref_blocks[k*$bits(sad_pkg::block_t) +: $bits(sad_pkg::block_t)]),
			.sad     (sads[k*sad_pkg::SAD_W +: sad_pkg::SAD_W])
		);
	end

	min_select_tree min_select_tree_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.sads    (sads),
		.min_sad (min_sad),
		.min_idx (min_idx)
	);

	// Raw enable and ctr_word, aligned inside the tracker
	best_match_tracker best_match_tracker_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.enable     (enable),
		.ctr_word   (ctr_word),
		.min_sad    (min_sad),
		.min_idx    (min_idx),
		.best_match (best_match)
	);

endmodule

`default_nettype wire

/* tb/tb_sad_model.svh */
`ifndef TB_SAD_MODEL_SVH
`define TB_SAD_MODEL_SVH

// Reference SAD of one 4x4 pair, row r column c at slot r*4 + c
function automatic sad_pkg::sad_t block_sad(
	input sad_pkg::block_t a,
	input sad_pkg::block_t b
);
	sad_pkg::sad_t acc;
	logic [7:0]    pa;
	logic [7:0]    pb;
	acc = '0;
	for (int r = 0; r < 4; r++)
	begin
		for (int c = 0; c < 4; c++)
		begin
			pa = a[(r*4 + c)*8 +: 8];
			pb = b[(r*4 + c)*8 +: 8];
			if (pa >= pb)
				acc = acc + sad_pkg::sad_t'(pa - pb);
			else
				acc = acc + sad_pkg::sad_t'(pb - pa);
		end
	end
	return acc;
endfunction

// Smallest of the sixteen SADs, lowest index on a tie, packed as a result word
function automatic search_pkg::match_t best_of_sixteen(
	input search_pkg::pe_blocks_t cur_b,
	input search_pkg::pe_blocks_t ref_b,
	input search_pkg::ctr_word_t  ctr
);
	sad_pkg::sad_t       best_sad;
	search_pkg::pe_idx_t best_idx;
	sad_pkg::sad_t       s;
	best_sad = block_sad(cur_b[0 +: 128], ref_b[0 +: 128]);
	best_idx = '0;
	for (int k = 1; k < 16; k++)
	begin
		s = block_sad(cur_b[k*128 +: 128], ref_b[k*128 +: 128]);
		if (s < best_sad)
		begin
			best_sad = s;
			best_idx = search_pkg::pe_idx_t'(k);
		end
	end
	return {best_sad, ctr, best_idx};
endfunction

`endif

/* tb/tb_me_calculate.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_me_calculate;

	parameter int SEED = 2;

	localparam int                 WAIT_LIMIT = 10;
	localparam int                 RUN_LEN    = 20;
	localparam int                 BLK_W      = 128;
	localparam search_pkg::match_t WORST      = 20'hFFF00; // SAD all ones, ctr 0, index 0

	typedef struct packed {
		logic               en;
		search_pkg::match_t m;
	} stage_t;

	logic                   clk = 1'b0;
	logic                   rst_n;
	logic                   enable;
	search_pkg::ctr_word_t  ctr_word;
	search_pkg::pe_blocks_t cur_blocks;
	search_pkg::pe_blocks_t ref_blocks;
	search_pkg::match_t     best_match;

	search_pkg::match_t exp_best;
	stage_t             model_q [$];
	int                 mismatch_count;
	int                 timeout_count;

	`include "tb_sad_model.svh"

	me_calculate me_calculate_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.enable     (enable),
		.ctr_word   (ctr_word),
		.cur_blocks (cur_blocks),
		.ref_blocks (ref_blocks),
		.best_match (best_match)
	);

	always #2 clk = ~clk;

	// Reference pipeline, sees the inputs the DUT samples at this edge
	always @(posedge clk)
	begin
		stage_t entry;
		stage_t used;
		entry.en = enable;
		entry.m  = best_of_sixteen(cur_blocks, ref_blocks, ctr_word);
		used     = '0;
		if (rst_n)
		begin
			model_q.delete(); // In-flight enables are lost
			exp_best = WORST;
		end
		else
		begin
			model_q.push_back(entry);
			if (model_q.size() > 4)
				used = model_q.pop_front(); // Sampled four edges ago
			if (!used.en)
				exp_best = WORST;
			else if (!(exp_best[19:8] < used.m[19:8]))
				exp_best = used.m; // Equal SAD also replaces
		end
	end

	always @(negedge clk)
	begin
		assert (best_match === exp_best)
		else
		begin
			mismatch_count++;
			$display("Mismatch at %0t: best_match %h, expected %h", $time, best_match, exp_best);
		end
	end

	function automatic search_pkg::pe_blocks_t random_blocks();
		search_pkg::pe_blocks_t b;
		for (int w = 0; w < $bits(search_pkg::pe_blocks_t) / 32; w++)
			b[w*32 +: 32] = $urandom();
		return b;
	endfunction

	function automatic search_pkg::ctr_word_t random_ctr();
		return search_pkg::ctr_word_t'($urandom_range(15, 0));
	endfunction

	task automatic drive_cycle(
		input logic                   en,
		input search_pkg::ctr_word_t  ctr,
		input search_pkg::pe_blocks_t cur_b,
		input search_pkg::pe_blocks_t ref_b
	);
		@(posedge clk);
		enable     <= en;
		ctr_word   <= ctr;
		cur_blocks <= cur_b;
		ref_blocks <= ref_b;
	endtask

	task automatic wait_for_match(input search_pkg::match_t want, input string what);
		bit seen;
		seen = 1'b0;
		for (int i = 0; i < WAIT_LIMIT && !seen; i++)
		begin
			@(negedge clk);
			if (best_match === want)
				seen = 1'b1;
		end
		if (!seen)
		begin
			timeout_count++;
			$display("Timeout at %0t: best_match never showed %h for %s", $time, want, what);
		end
	endtask

	// One enabled cycle, then enable low until the result clears
	task automatic single_shot(
		input search_pkg::ctr_word_t  ctr,
		input search_pkg::pe_blocks_t cur_b,
		input search_pkg::pe_blocks_t ref_b,
		input search_pkg::match_t     want,
		input string                  what
	);
		drive_cycle(1'b1, ctr, cur_b, ref_b);
		drive_cycle(1'b0, ctr, cur_b, ref_b);
		wait_for_match(want, what);
		wait_for_match(WORST, {what, " cleared"});
	endtask

	initial
	begin
		search_pkg::pe_blocks_t cur_b;
		search_pkg::pe_blocks_t ref_b;
		sad_pkg::block_t        pat;
		int                     tie_idx [4];
		void'($urandom(SEED));
		tie_idx        = '{14, 6, 9, 5};
		rst_n          = 1'b1;
		enable         = 1'b0;
		ctr_word       = '0;
		cur_blocks     = '0;
		ref_blocks     = '0;
		exp_best       = WORST;
		mismatch_count = 0;
		timeout_count  = 0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b0;

		repeat (5) drive_cycle(1'b0, 4'h0, '0, '0);
		wait_for_match(WORST, "idle after reset");

		cur_b = random_blocks();
		ref_b = random_blocks();
		single_shot(4'hA, cur_b, ref_b, best_of_sixteen(cur_b, ref_b, 4'hA), "single cycle");

		for (int i = 0; i < RUN_LEN; i++)
			drive_cycle(1'b1, random_ctr(), random_blocks(), random_blocks());
		repeat (6) drive_cycle(1'b0, 4'h0, '0, '0);

		// Same blocks twice, the equal SAD takes the second ctr word
		cur_b = random_blocks();
		ref_b = random_blocks();
		drive_cycle(1'b1, 4'h3, cur_b, ref_b);
		single_shot(4'h9, cur_b, ref_b, best_of_sixteen(cur_b, ref_b, 4'h9), "equal SAD");

		cur_b = random_blocks();
		ref_b = random_blocks();
		pat   = ref_b[3*BLK_W +: BLK_W];
		foreach (tie_idx[t])
		begin
			cur_b[tie_idx[t]*BLK_W +: BLK_W] = pat;
			ref_b[tie_idx[t]*BLK_W +: BLK_W] = pat;
		end
		single_shot(4'h6, cur_b, ref_b, 20'h00065, "tie across elements");

		cur_b = random_blocks();
		single_shot(4'hC, cur_b, cur_b, 20'h000C0, "zero SAD");
		single_shot(4'h5, '0, '1, {12'd4080, 8'h50}, "full scale SAD");

		for (int i = 0; i < 6; i++)
			drive_cycle(1'b1, random_ctr(), random_blocks(), random_blocks());
		@(posedge clk);
		rst_n <= 1'b1; // Reset in the middle of the run
		wait_for_match(WORST, "reset during run");
		@(posedge clk);
		rst_n <= 1'b0;
		for (int i = 0; i < 8; i++)
			drive_cycle(1'b1, random_ctr(), random_blocks(), random_blocks());
		drive_cycle(1'b0, 4'h0, '0, '0);
		wait_for_match(WORST, "idle after restart");
		repeat (3) drive_cycle(1'b0, 4'h0, '0, '0);

		$display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
		if (mismatch_count == 0 && timeout_count == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+tb
logic/sad_pkg.sv
logic/search_pkg.sv
logic/sad_pe.sv
logic/min_select_tree.sv
logic/best_match_tracker.sv
logic/me_calculate.sv
tb/tb_me_calculate.sv

/* Makefile */
# Verilator flow for the motion estimation testbench

VERILATOR  ?= verilator
TOP        ?= tb_me_calculate
RTL_TOP    ?= me_calculate
SEED       ?= 2
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) \
		-f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "TEST PASSED" $(LOG); then \
		echo "Simulation ended without a verdict"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) \
		logic/sad_pkg.sv logic/search_pkg.sv logic/sad_pe.sv \
		logic/min_select_tree.sv logic/best_match_tracker.sv logic/me_calculate.sv

clean:
	rm -rf $(BUILD_DIR) $(LOG)
